/* Makefile */
# Verilator build and run for the instruction fetch unit testbench

all: run

compile:
	verilator --binary --timing -f all.f --top-module tb_ifu -Mdir obj_dir -o sim_ifu

# the run passes only if the pass message shows up in the output
run: compile
	@out=$$(./obj_dir/sim_ifu); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

/* all.f */
rtl/ifu_pkg.sv
rtl/fetch_fifo.sv
rtl/pc_select.sv
rtl/prefetch_ctrl.sv
rtl/if_id_reg.sv
rtl/ifu_top.sv
tests/tb_ifu.sv

/* rtl/fetch_fifo.sv */
// small circular FIFO with a type parameter for the payload
// flush empties it in one cycle, a push in the same cycle still lands
module fetch_fifo #(
  parameter type entry_t = logic [ifu_pkg::XLEN-1:0]
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          flush_i,
  input  logic          push_i,
  input  entry_t        push_data_i,
  input  logic          pop_i,
  output entry_t        pop_data_o,
  output logic          empty_o,
  output logic          full_o,
  output ifu_pkg::cnt_t count_o
);
  import ifu_pkg::*;

  entry_t mem_q [FIFO_DEPTH];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  ptr_t   wr_idx;
  cnt_t   count_q;
  logic   push_ok;
  logic   pop_ok;

  // wrap at the buffer depth, also for depths that are not a power of two
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == cnt_t'(FIFO_DEPTH));
  assign count_o    = count_q;
  assign pop_data_o = mem_q[rd_ptr_q];

  // a pop frees its slot for a push in the same cycle
  assign pop_ok  = pop_i & ~empty_o & ~flush_i;
  assign push_ok = push_i & (flush_i | ~full_o | pop_ok);
  // after a flush the write restarts at slot 0
  assign wr_idx  = flush_i ? '0 : wr_ptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= push_ok ? ptr_inc('0) : '0;
      count_q  <= cnt_t'(push_ok);
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + cnt_t'(push_ok) - cnt_t'(pop_ok);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_idx] <= push_data_i;
    end
  end

endmodule

/* rtl/if_id_reg.sv */
// IF-ID pipeline register
// holds the instruction for ID with its valid and new flags
module if_id_reg (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_valid_i,
  input  ifu_pkg::fetch_entry_t fetch_i,
  output logic                  fetch_ready_o,
  input  logic                  id_in_ready_i,
  input  logic                  pc_set_i,
  input  logic                  instr_valid_clear_i,
  output logic                  instr_valid_id_o,
  output logic                  instr_new_id_o,
  output ifu_pkg::if_id_t       if_id_o
);
  import ifu_pkg::*;

  logic   accept;
  logic   valid_d, valid_q;
  logic   new_q;
  if_id_t if_id_d, if_id_q;

  // ID takes a word whenever it is ready
  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;

  // register content from the head of the word buffer
  assign if_id_d.instr     = fetch_i.rdata;
  assign if_id_d.pc        = fetch_i.addr;
  assign if_id_d.fetch_err = fetch_i.err;

  // a redirect in the same cycle squashes the incoming word
  // otherwise valid holds until ID clears it
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one cycle pulse per accepted word
      new_q   <= accept;
    end
  end

  // frozen while ID stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      if_id_q <= '0;
    end else if (accept) begin
      if_id_q <= if_id_d;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign if_id_o          = if_id_q;

endmodule

/* rtl/ifu_pkg.sv */
// instruction fetch unit package
// widths, fixed entry addresses, next-pc selectors
// and the structs passed between the fetch blocks
package ifu_pkg;

  ////////////////////////////////////////
  // widths and fixed addresses
  ////////////////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // low bits forced to zero on the boot and mtvec base
  localparam int unsigned BOOT_ALIGN_BITS = 8;

  // debug module entry points
  localparam logic [XLEN-1:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [XLEN-1:0] DM_EXC_ADDR  = 32'h1A11_0808;

  // entries per prefetch buffer, also the limit on requests in flight
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W      = $clog2(FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;
  // one extra bit so two counts can be added without overflow
  typedef logic [CNT_W:0]   sum_t;

  ////////////////////////////////////////
  // selectors
  ////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // top bit marks an interrupt, low bits carry the interrupt id
  typedef struct packed {
    logic       irq;
    logic [4:0] id;
  } exc_cause_t;

  // csr values the fetch unit jumps to
  typedef struct packed {
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] depc;
    logic [XLEN-1:0] mtvec;
  } csr_pc_t;

  // one returned word with its address and bus error
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
    logic            err;
  } fetch_entry_t;

  // content of the IF-ID register
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            fetch_err;
  } if_id_t;

endpackage

/* rtl/ifu_top.sv */
// instruction fetch unit top level
// pc selection, prefetch control and the IF-ID register
module ifu_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                 [ifu_pkg::XLEN-1:0] boot_addr_i,
  input  logic                                 req_i,
  input  logic                                 pc_set_i,
  input  ifu_pkg::pc_sel_e                     pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e                 exc_pc_mux_i,
  input  ifu_pkg::exc_cause_t                  exc_cause_i,
  input  logic                 [ifu_pkg::XLEN-1:0] branch_target_i,
  input  ifu_pkg::csr_pc_t                     csr_pc_i,
  input  logic                                 id_in_ready_i,
  input  logic                                 instr_valid_clear_i,
  // instruction bus
  output logic                                 instr_req_o,
  output logic                 [ifu_pkg::XLEN-1:0] instr_addr_o,
  input  logic                                 instr_gnt_i,
  input  logic                                 instr_rvalid_i,
  input  logic                 [ifu_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                                 instr_err_i,
  // towards csr and ID
  output logic                                 csr_mtvec_init_o,
  output logic                                 instr_valid_id_o,
  output logic                                 instr_new_id_o,
  output ifu_pkg::if_id_t                      if_id_o,
  output logic                 [ifu_pkg::XLEN-1:0] pc_if_o,
  output logic                                 if_busy_o
);
  import ifu_pkg::*;

  logic            branch;
  logic [XLEN-1:0] fetch_addr;
  logic            fetch_valid;
  logic            fetch_ready;
  fetch_entry_t    fetch;

  // next address
  pc_select pc_select_i (
    .boot_addr_i     (boot_addr_i),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .exc_cause_i     (exc_cause_i),
    .branch_target_i (branch_target_i),
    .csr_pc_i        (csr_pc_i),
    .fetch_addr_o    (fetch_addr),
    .branch_o        (branch),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  // bus side and word buffer
  prefetch_ctrl prefetch_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch),
    .branch_addr_i (fetch_addr),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .fetch_valid_o (fetch_valid),
    .fetch_o       (fetch),
    .fetch_ready_i (fetch_ready),
    .busy_o        (if_busy_o)
  );

  // hand over to ID
  if_id_reg if_id_reg_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid),
    .fetch_i            (fetch),
    .fetch_ready_o      (fetch_ready),
    .id_in_ready_i      (id_in_ready_i),
    .pc_set_i           (pc_set_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .if_id_o            (if_id_o)
  );

  // pc of the word at the head of the buffer
  assign pc_if_o = fetch.addr;

endmodule

/* rtl/pc_select.sv */
// next fetch address selection
// exception vector mux, main pc mux and the mtvec init strobe
module pc_select (
  input  logic                     [ifu_pkg::XLEN-1:0] boot_addr_i,
  input  logic                                         pc_set_i,
  input  ifu_pkg::pc_sel_e                             pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e                         exc_pc_mux_i,
  input  ifu_pkg::exc_cause_t                          exc_cause_i,
  input  logic                     [ifu_pkg::XLEN-1:0] branch_target_i,
  input  ifu_pkg::csr_pc_t                             csr_pc_i,
  output logic                     [ifu_pkg::XLEN-1:0] fetch_addr_o,
  output logic                                         branch_o,
  output logic                                         csr_mtvec_init_o
);
  import ifu_pkg::*;

  logic [XLEN-1:0] boot_base;
  logic [XLEN-1:0] mtvec_base;
  logic [XLEN-1:0] irq_offset;
  logic [XLEN-1:0] exc_pc;
  logic [XLEN-1:0] next_pc;

  // boot and trap bases are 256 byte aligned
  assign boot_base  = {boot_addr_i[XLEN-1:BOOT_ALIGN_BITS], {BOOT_ALIGN_BITS{1'b0}}};
  assign mtvec_base = {csr_pc_i.mtvec[XLEN-1:BOOT_ALIGN_BITS], {BOOT_ALIGN_BITS{1'b0}}};

  // vectored mode, one word per interrupt id
  assign irq_offset = XLEN'({exc_cause_i.id, 2'b00});

  // exception target
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: next_pc = boot_base;
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap
      PC_ERET: next_pc = csr_pc_i.mepc;
      // return from debug mode
      PC_DRET: next_pc = csr_pc_i.depc;
      default: next_pc = boot_base;
    endcase
  end

  // only full words are fetched
  assign fetch_addr_o = {next_pc[XLEN-1:2], 2'b00};
  assign branch_o     = pc_set_i;

  // mtvec takes its reset value from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

/* rtl/prefetch_ctrl.sv */
// prefetch control for the instruction bus
// issues requests, tracks them in flight, drops stale responses
// and buffers returned words for the IF-ID register
module prefetch_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  logic                                  branch_i,
  input  logic              [ifu_pkg::XLEN-1:0] branch_addr_i,
  output logic                                  instr_req_o,
  output logic              [ifu_pkg::XLEN-1:0] instr_addr_o,
  input  logic                                  instr_gnt_i,
  input  logic                                  instr_rvalid_i,
  input  logic              [ifu_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                                  instr_err_i,
  output logic                                  fetch_valid_o,
  output ifu_pkg::fetch_entry_t                 fetch_o,
  input  logic                                  fetch_ready_i,
  output logic                                  busy_o
);
  import ifu_pkg::*;

  logic [XLEN-1:0] addr_q, addr_d, addr_base;
  logic [XLEN-1:0] hold_addr_q;
  logic [XLEN-1:0] pending_addr;
  logic            req_hold_q, stale_q;
  logic            cur_stale, room;
  logic            gnt_kept, gnt_stale;
  logic            rsp_drop, rsp_keep;
  cnt_t            discard_q, discard_d;
  cnt_t            pending_cnt, fetched_cnt;
  sum_t            inflight_cnt, buffered_cnt;
  logic            pending_empty, fetched_empty;
  fetch_entry_t    fetched_in;

  ////////////////////////////////////////
  // request issue
  ////////////////////////////////////////

  // all requests on the bus, kept or owed to a squashed stream
  assign inflight_cnt = {1'b0, pending_cnt} + {1'b0, discard_q};
  // slots a response may still need, both buffers are flushed on a branch
  assign buffered_cnt = branch_i ? '0 : ({1'b0, pending_cnt} + {1'b0, fetched_cnt});
  assign room = (inflight_cnt < sum_t'(FIFO_DEPTH)) & (buffered_cnt < sum_t'(FIFO_DEPTH));

  // an ungranted request keeps its address whatever happens upstream
  assign instr_req_o  = req_hold_q | (req_i & room);
  assign addr_base    = branch_i ? branch_addr_i : addr_q;
  assign instr_addr_o = req_hold_q ? hold_addr_q : addr_base;

  // the held request belongs to the old stream once a branch has been seen
  assign cur_stale = req_hold_q & (stale_q | branch_i);
  assign gnt_kept  = instr_req_o & instr_gnt_i & ~cur_stale;
  assign gnt_stale = instr_req_o & instr_gnt_i & cur_stale;

  // next address steps by one word per kept grant
  assign addr_d = gnt_kept ? addr_base + XLEN'(4) : addr_base;

  ////////////////////////////////////////
  // responses
  ////////////////////////////////////////

  // responses come back in order, so owed ones always arrive first
  assign rsp_drop = instr_rvalid_i & ((discard_q != '0) | branch_i);
  assign rsp_keep = instr_rvalid_i & ~rsp_drop;

  // on a branch every kept request in flight turns into one to drop
  assign discard_d = discard_q + (branch_i ? pending_cnt : '0) + cnt_t'(gnt_stale)
                     - cnt_t'(rsp_drop);

  assign fetched_in.rdata = instr_rdata_i;
  assign fetched_in.addr  = pending_addr;
  assign fetched_in.err   = instr_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      req_hold_q <= 1'b0;
      stale_q    <= 1'b0;
      discard_q  <= '0;
    end else begin
      addr_q     <= addr_d;
      req_hold_q <= instr_req_o & ~instr_gnt_i;
      stale_q    <= cur_stale & ~instr_gnt_i;
      discard_q  <= discard_d;
    end
  end

  // address of the request waiting for its grant
  always_ff @(posedge clk_i) begin
    if (instr_req_o & ~instr_gnt_i) begin
      hold_addr_q <= instr_addr_o;
    end
  end

  // addresses of kept requests still waiting for data
  fetch_fifo #(
    .entry_t(logic [XLEN-1:0])
  ) pending_addr_q (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (branch_i),
    .push_i     (gnt_kept),
    .push_data_i(instr_addr_o),
    .pop_i      (rsp_keep),
    .pop_data_o (pending_addr),
    .empty_o    (pending_empty),
    .full_o     (),
    .count_o    (pending_cnt)
  );

  // returned words waiting for ID
  fetch_fifo #(
    .entry_t(fetch_entry_t)
  ) fetched_q (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (branch_i),
    .push_i     (rsp_keep),
    .push_data_i(fetched_in),
    .pop_i      (fetch_valid_o & fetch_ready_i),
    .pop_data_o (fetch_o),
    .empty_o    (fetched_empty),
    .full_o     (),
    .count_o    (fetched_cnt)
  );

  assign fetch_valid_o = ~fetched_empty;
  assign busy_o        = ~pending_empty | (discard_q != '0);

endmodule

/* tests/ifu_stim.txt */
// columns: pc_mux exc_pc_mux cause value accept_count expected_first_pc
// pc_mux 0 boot, 1 jump, 2 exc, 3 eret, 4 dret; value goes to the selected source
// boot address with its low 8 bits dropped
0 0 00 00001234 6 00001200
// plain jump
1 0 00 00002000 5 00002000
// jump that runs through the error window
1 0 00 00002FF8 8 00002FF8
// return from trap to mepc
3 0 00 00004444 4 00004444
// return from debug, depc low bits cleared
4 0 00 00005006 4 00005004
// synchronous exception to the mtvec base
2 0 00 000080A4 5 00008000
// vectored interrupt id 5
2 1 25 00008000 4 00008014
// vectored interrupt id 31 on an unaligned mtvec
2 1 3F 0000C155 4 0000C17C
// debug halt entry
2 2 00 00000000 4 1A110800
// debug exception entry
2 3 00 00000000 4 1A110808
// jump near address zero
1 0 00 00000010 6 00000010
// return from trap into the error window
3 0 00 00003004 3 00003004
// second boot after the base moved
0 0 00 000060FF 5 00006000
// end of list
FF 0 0 0 0 0

/* tests/tb_ifu.sv */
// testbench for the instruction fetch unit
// clock and reset, instruction bus memory model, stimulus reader and checks
module tb_ifu;
  timeunit 1ns;
  timeprecision 1ps;
  import ifu_pkg::*;

  // memory model data key and error window with an exclusive end
  localparam logic [XLEN-1:0] DATA_KEY = 32'hA5C3_0F96;
  localparam logic [XLEN-1:0] ERR_LO   = 32'h0000_3000;
  localparam logic [XLEN-1:0] ERR_HI   = 32'h0000_3010;
  // cycles allowed between two instructions reaching ID
  localparam int unsigned     WAIT_MAX = 200;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic [XLEN-1:0] boot_addr_i;
  logic            req_i;
  logic            pc_set_i;
  pc_sel_e         pc_mux_i;
  exc_pc_sel_e     exc_pc_mux_i;
  exc_cause_t      exc_cause_i;
  logic [XLEN-1:0] branch_target_i;
  csr_pc_t         csr_pc_i;
  logic            id_in_ready_i;
  logic            instr_valid_clear_i;
  logic            instr_req_o;
  logic [XLEN-1:0] instr_addr_o;
  logic            instr_gnt_i = 1'b0;
  logic            instr_rvalid_i = 1'b0;
  logic [XLEN-1:0] instr_rdata_i = '0;
  logic            instr_err_i = 1'b0;
  logic            csr_mtvec_init_o;
  logic            instr_valid_id_o;
  logic            instr_new_id_o;
  if_id_t          if_id_o;
  logic [XLEN-1:0] pc_if_o;
  logic            if_busy_o;

  // six words per redirect as laid out in the stimulus file
  logic [31:0]     stim_mem [0:255];
  logic [31:0]     lfsr_q = 32'h66dd_e358;
  // memory model state
  logic [XLEN-1:0] bus_addr_q[$];
  int              bus_due_q[$];
  int              cyc = 0;
  int              gnt_wait = 0;

  ifu_top dut_i (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // galois lfsr stepped once per bit taken
  function automatic logic [3:0] rand_bits(input int unsigned n);
    logic [3:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val    = {val[2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // 0 to 2 extra cycles
  function automatic int rand_delay();
    logic [3:0] v;
    v = rand_bits(2);
    return (v > 4'd2) ? 2 : int'(v);
  endfunction

  function automatic logic in_err_window(input logic [XLEN-1:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////
  // instruction bus memory model
  ////////////////////////////////////////

  // handshakes are taken from the values before the edge
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (instr_rvalid_i) begin
      void'(bus_addr_q.pop_front());
      void'(bus_due_q.pop_front());
    end
    if (instr_req_o && instr_gnt_i) begin
      bus_addr_q.push_back(instr_addr_o);
      // answer 1 to 3 cycles after the grant
      bus_due_q.push_back(cyc + rand_delay());
      gnt_wait = rand_delay();
    end else if (instr_req_o && gnt_wait > 0) begin
      gnt_wait = gnt_wait - 1;
    end
  end

  // in order responses with at most one per cycle
  always @(negedge clk_i) begin
    if (rst_ni && bus_addr_q.size() == 0) begin
      check_value("busy with no request in flight", XLEN'(if_busy_o), '0);
    end
    instr_gnt_i = (gnt_wait == 0);
    if (bus_addr_q.size() != 0 && cyc >= bus_due_q[0]) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = bus_addr_q[0] ^ DATA_KEY;
      instr_err_i    = in_err_window(bus_addr_q[0]);
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
    end
  end

  ////////////////////////////////////////
  // one redirect and its instructions
  ////////////////////////////////////////

  // called and left at a falling edge
  task automatic run_redirect(input logic [31:0] sel, input logic [31:0] exc,
                              input logic [31:0] cause, input logic [31:0] value,
                              input logic [31:0] count, input logic [31:0] first_pc);
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] head_pc;
    int unsigned     got;
    int unsigned     waited;
    int              stall_left;
    logic            stalled_q;
    logic            stall_done;
    logic            valid_exp;
    logic            clear_q;
    logic [3:0]      r;
    if_id_t          held;
    pc_mux_i     = pc_sel_e'(sel[2:0]);
    exc_pc_mux_i = exc_pc_sel_e'(exc[1:0]);
    exc_cause_i  = exc_cause_t'(cause[5:0]);
    case (pc_sel_e'(sel[2:0]))
      PC_BOOT: boot_addr_i = value;
      PC_JUMP: branch_target_i = value;
      PC_EXC:  csr_pc_i.mtvec = value;
      PC_ERET: csr_pc_i.mepc = value;
      default: csr_pc_i.depc = value;
    endcase
    // ID is flushed along with the redirect
    req_i               = 1'b1;
    id_in_ready_i       = 1'b1;
    pc_set_i            = 1'b1;
    instr_valid_clear_i = 1'b1;
    @(posedge clk_i);
    check_value("mtvec init strobe", XLEN'(csr_mtvec_init_o), XLEN'(pc_mux_i == PC_BOOT));
    @(negedge clk_i);
    pc_set_i            = 1'b0;
    instr_valid_clear_i = 1'b0;
    // a word taken in the redirect cycle must not be valid
    check_value("valid after redirect", XLEN'(instr_valid_id_o), '0);
    exp_pc     = first_pc;
    head_pc    = pc_if_o;
    got        = 0;
    waited     = 0;
    stall_left = 0;
    stalled_q  = 1'b0;
    stall_done = 1'b0;
    valid_exp  = 1'b0;
    clear_q    = 1'b0;
    while (got < count) begin
      @(negedge clk_i);
      // the strobe belongs to the redirect cycle only
      check_value("mtvec init without redirect", XLEN'(csr_mtvec_init_o), '0);
      if (stalled_q) begin
        check_value("new pulse while stalled", XLEN'(instr_new_id_o), '0);
        check_value("held instr", if_id_o.instr, held.instr);
        check_value("held pc", if_id_o.pc, held.pc);
        check_value("held fetch error", XLEN'(if_id_o.fetch_err), XLEN'(held.fetch_err));
      end
      if (instr_new_id_o) begin
        check_value("pc at IF head", head_pc, exp_pc);
        check_value("pc in ID", if_id_o.pc, exp_pc);
        check_value("instr in ID", if_id_o.instr, exp_pc ^ DATA_KEY);
        check_value("fetch error", XLEN'(if_id_o.fetch_err), XLEN'(in_err_window(exp_pc)));
        valid_exp = 1'b1;
        exp_pc    = exp_pc + XLEN'(4);
        got++;
        waited = 0;
      end else begin
        valid_exp = valid_exp & ~clear_q;
        waited++;
        if (waited > WAIT_MAX) begin
          $display("Timeout: instruction %0d after redirect to %h never reached ID",
                   got, first_pc);
          $display("Simulation FAILED");
          $fatal(1, "wait loop timed out");
        end
      end
      check_value("valid flag", XLEN'(instr_valid_id_o), XLEN'(valid_exp));
      // random clear strobe from ID
      r                   = rand_bits(1);
      clear_q             = r[0];
      instr_valid_clear_i = clear_q;
      // one stall of 1 to 8 cycles per redirect
      if (stall_left != 0) begin
        stall_left--;
      end else if (got == 2 && !stall_done) begin
        stall_left = int'(rand_bits(3)) + 1;
        stall_done = 1'b1;
        held       = if_id_o;
      end
      id_in_ready_i = (stall_left == 0);
      stalled_q     = (stall_left != 0);
      // word buffer head that ID may take at the next rising edge
      head_pc       = pc_if_o;
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : stimulus
    logic [7:0] base;
    rst_ni              = 1'b0;
    boot_addr_i         = '0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_i     = '0;
    csr_pc_i            = '0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    $readmemh("tests/ifu_stim.txt", stim_mem);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // idle state after reset
    check_value("req after reset", XLEN'(instr_req_o), '0);
    check_value("valid after reset", XLEN'(instr_valid_id_o), '0);
    check_value("new after reset", XLEN'(instr_new_id_o), '0);
    check_value("busy after reset", XLEN'(if_busy_o), '0);
    check_value("mtvec init after reset", XLEN'(csr_mtvec_init_o), '0);
    check_value("instr after reset", if_id_o.instr, '0);
    check_value("pc after reset", if_id_o.pc, '0);
    check_value("fetch error after reset", XLEN'(if_id_o.fetch_err), '0);
    // ff in the selector column ends the list
    base = 8'd0;
    while (base < 8'd250 && stim_mem[base] != 32'hFF) begin
      run_redirect(stim_mem[base], stim_mem[base+8'd1], stim_mem[base+8'd2],
                   stim_mem[base+8'd3], stim_mem[base+8'd4], stim_mem[base+8'd5]);
      base = base + 8'd6;
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule
